// ==== adapter_params.svh ====
// bridge width and count macros

`ifndef ADAPTER_PARAMS_SVH
`define ADAPTER_PARAMS_SVH

// axi4-lite side
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// apb side, one byte per transfer
`define APB_DATA_W 8

// shared by both buses
`define ADDR_W 16

// byte transfers per axi word
`define SEG_COUNT 4
`define SEG_IDX_W 2

`endif

// ==== apb_pkg.sv ====
// APB side types

`default_nettype none

`include "adapter_params.svh"

package apb_pkg;

    typedef logic [`APB_DATA_W-1:0] apb_data_t;
    typedef logic [`SEG_IDX_W-1:0] seg_idx_t;

    // first setup phase of a transfer is spent in idle
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SETUP  = 2'd1,
        ST_ACCESS = 2'd2
    } apb_state_t;

endpackage

`default_nettype wire

// ==== apb_seg_lane.sv ====
// one byte lane of the bridge

`timescale 1ns/1ns
`default_nettype none

module apb_seg_lane (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire apb_pkg::seg_idx_t  lane_idx,
    input  wire logic               load,
    input  wire apb_pkg::apb_data_t wbyte,
    input  wire logic               wbit,
    input  wire apb_pkg::seg_idx_t  first_seg,
    input  wire apb_pkg::seg_idx_t  cur_seg,
    input  wire logic               seg_done,
    input  wire apb_pkg::apb_data_t prdata,
    output apb_pkg::apb_data_t      lane_wdata,
    output logic                    lane_strb,
    output apb_pkg::apb_data_t      lane_rdata
);
    import apb_pkg::*;

    apb_data_t wbyte_q;
    apb_data_t rbyte_q;
    logic      strb_q;
    logic      strb_in;
    logic      hit;

    // lanes below the start segment are never written
    assign strb_in = wbit && (lane_idx >= first_seg);
    assign hit     = seg_done && (cur_seg == lane_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            strb_q <= 1'b0;
        end else if (load) begin
            strb_q <= strb_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wbyte_q <= wbyte;
            rbyte_q <= '0;
        end else if (hit) begin
            rbyte_q <= prdata;
        end
    end

    // bypass so the first setup phase and the final byte see fresh data
    assign lane_wdata = load ? wbyte : wbyte_q;
    assign lane_strb  = load ? strb_in : strb_q;
    assign lane_rdata = hit ? prdata : rbyte_q;

endmodule

`default_nettype wire

// ==== apb_seq.sv ====
// APB transfer sequencer

`timescale 1ns/1ns
`default_nettype none

`include "adapter_params.svh"

module apb_seq (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire axil_pkg::axil_op_t   op,
    input  wire axil_pkg::axil_addr_t addr,
    input  wire logic [2:0]           prot,
    input  wire apb_pkg::seg_idx_t    first_seg,
    input  wire axil_pkg::axil_data_t lane_wdata_bus,
    input  wire axil_pkg::axil_strb_t lane_strb_bus,
    input  wire logic                 pready,
    input  wire logic                 pslverr,
    output logic                      busy,
    output apb_pkg::seg_idx_t         cur_seg,
    output logic                      seg_done,
    output logic                      seg_err,
    output logic                      xfer_done,
    output axil_pkg::axil_addr_t      paddr,
    output logic [2:0]                pprot,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output apb_pkg::apb_data_t        pwdata,
    output logic                      pstrb
);
    import axil_pkg::*;
    import apb_pkg::*;

    apb_state_t state;
    apb_state_t state_next;
    seg_idx_t   seg_q;
    seg_idx_t   sel_seg;
    logic       last_seg;

    // the start cycle doubles as the first setup phase
    assign sel_seg  = start ? first_seg : seg_q;
    assign last_seg = (seg_q == seg_idx_t'(`SEG_COUNT - 1));

    assign seg_done  = (state == ST_ACCESS) && pready;
    assign seg_err   = seg_done && pslverr;
    assign xfer_done = seg_done && last_seg;
    assign busy      = start || (state != ST_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_ACCESS;
                end
            end
            ST_SETUP: begin
                state_next = ST_ACCESS;
            end
            ST_ACCESS: begin
                if (pready) begin
                    state_next = last_seg ? ST_IDLE : ST_SETUP;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            seg_q <= '0;
        end else begin
            state <= state_next;
            if (start) begin
                seg_q <= first_seg;
            end else if (seg_done && !last_seg) begin
                // step up to the next byte lane
                seg_q <= seg_q + 1'b1;
            end
        end
    end

    assign cur_seg = sel_seg;

    // low address bits track the lane being transferred
    assign paddr   = {addr[`ADDR_W-1:`SEG_IDX_W], sel_seg};
    assign pprot   = prot;
    assign pwrite  = (op == OP_WRITE);
    assign psel    = busy;
    assign penable = (state == ST_ACCESS);

    assign pwdata = lane_wdata_bus[sel_seg*`APB_DATA_W +: `APB_DATA_W];
    assign pstrb  = lane_strb_bus[sel_seg];

endmodule

`default_nettype wire

// ==== axil_apb_bridge.sv ====
// AXI4-Lite to APB bridge

`timescale 1ns/1ns
`default_nettype none

`include "adapter_params.svh"

module axil_apb_bridge (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire axil_pkg::axil_addr_t awaddr,
    input  wire logic [2:0]           awprot,
    input  wire logic                 awvalid,
    output logic                      awready,
    input  wire axil_pkg::axil_data_t wdata,
    input  wire axil_pkg::axil_strb_t wstrb,
    input  wire logic                 wvalid,
    output logic                      wready,
    output axil_pkg::axil_resp_t      bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    input  wire axil_pkg::axil_addr_t araddr,
    input  wire logic [2:0]           arprot,
    input  wire logic                 arvalid,
    output logic                      arready,
    output axil_pkg::axil_data_t      rdata,
    output axil_pkg::axil_resp_t      rresp,
    output logic                      rvalid,
    input  wire logic                 rready,
    output axil_pkg::axil_addr_t      paddr,
    output logic [2:0]                pprot,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output apb_pkg::apb_data_t        pwdata,
    output logic                      pstrb,
    input  wire apb_pkg::apb_data_t   prdata,
    input  wire logic                 pready,
    input  wire logic                 pslverr
);
    import axil_pkg::*;
    import apb_pkg::*;

    logic       start;
    logic       load;
    axil_op_t   op;
    axil_addr_t addr;
    logic [2:0] prot;
    seg_idx_t   first_seg;
    axil_data_t lane_wdata_in;
    axil_strb_t lane_wstrb_in;
    logic       busy;
    seg_idx_t   cur_seg;
    logic       seg_done;
    logic       seg_err;
    logic       xfer_done;
    axil_data_t lane_wdata_bus;
    axil_strb_t lane_strb_bus;
    axil_data_t lane_rdata_bus;
    logic       b_free;
    logic       r_free;

    axil_req_arbiter arb_i (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid),
        .b_free(b_free), .r_free(r_free), .busy(busy),
        .awready(awready), .wready(wready), .arready(arready),
        .start(start), .load(load), .op(op), .addr(addr), .prot(prot),
        .first_seg(first_seg),
        .lane_wdata_in(lane_wdata_in), .lane_wstrb_in(lane_wstrb_in)
    );

    // lane i carries byte i of the axi word
    for (genvar i = 0; i < `SEG_COUNT; i++) begin : g_lane
        apb_seg_lane lane_i (
            .clk(clk), .rst(rst),
            .lane_idx(seg_idx_t'(i)),
            .load(load),
            .wbyte(lane_wdata_in[i*`APB_DATA_W +: `APB_DATA_W]),
            .wbit(lane_wstrb_in[i]),
            .first_seg(first_seg), .cur_seg(cur_seg),
            .seg_done(seg_done), .prdata(prdata),
            .lane_wdata(lane_wdata_bus[i*`APB_DATA_W +: `APB_DATA_W]),
            .lane_strb(lane_strb_bus[i]),
            .lane_rdata(lane_rdata_bus[i*`APB_DATA_W +: `APB_DATA_W])
        );
    end

    apb_seq seq_i (
        .clk(clk), .rst(rst),
        .start(start), .op(op), .addr(addr), .prot(prot), .first_seg(first_seg),
        .lane_wdata_bus(lane_wdata_bus), .lane_strb_bus(lane_strb_bus),
        .pready(pready), .pslverr(pslverr),
        .busy(busy), .cur_seg(cur_seg), .seg_done(seg_done),
        .seg_err(seg_err), .xfer_done(xfer_done),
        .paddr(paddr), .pprot(pprot), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb)
    );

    axil_resp_gen resp_i (
        .clk(clk), .rst(rst),
        .op(op), .xfer_done(xfer_done), .seg_err(seg_err),
        .lane_rdata_bus(lane_rdata_bus),
        .bready(bready), .rready(rready),
        .bvalid(bvalid), .bresp(bresp),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
        .b_free(b_free), .r_free(r_free)
    );

endmodule

`default_nettype wire

// ==== axil_pkg.sv ====
// AXI4-Lite side types

`default_nettype none

`include "adapter_params.svh"

package axil_pkg;

    typedef logic [`ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;

    // exokay and decerr never produced
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } axil_op_t;

endpackage

`default_nettype wire

// ==== axil_req_arbiter.sv ====
// AXI4-Lite request arbiter

`timescale 1ns/1ns
`default_nettype none

`include "adapter_params.svh"

module axil_req_arbiter (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire axil_pkg::axil_addr_t awaddr,
    input  wire logic [2:0]           awprot,
    input  wire logic                 awvalid,
    input  wire axil_pkg::axil_data_t wdata,
    input  wire axil_pkg::axil_strb_t wstrb,
    input  wire logic                 wvalid,
    input  wire axil_pkg::axil_addr_t araddr,
    input  wire logic [2:0]           arprot,
    input  wire logic                 arvalid,
    input  wire logic                 b_free,
    input  wire logic                 r_free,
    input  wire logic                 busy,
    output logic                      awready,
    output logic                      wready,
    output logic                      arready,
    output logic                      start,
    output logic                      load,
    output axil_pkg::axil_op_t        op,
    output axil_pkg::axil_addr_t      addr,
    output logic [2:0]                prot,
    output apb_pkg::seg_idx_t         first_seg,
    output axil_pkg::axil_data_t      lane_wdata_in,
    output axil_pkg::axil_strb_t      lane_wstrb_in
);
    import axil_pkg::*;

    logic       awready_q;
    logic       wready_q;
    logic       arready_q;
    logic       start_q;
    logic       last_read;
    axil_addr_t addr_q;
    logic [2:0] prot_q;
    axil_data_t wdata_q;
    axil_strb_t wstrb_q;

    logic write_ok;
    logic read_ok;
    logic grant_wr;
    logic grant_rd;

    assign write_ok = awvalid && wvalid && b_free && !busy;
    assign read_ok  = arvalid && r_free && !busy;

    // alternate when both are waiting
    assign grant_wr = write_ok && (!read_ok || last_read);
    assign grant_rd = read_ok && !grant_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
            start_q   <= 1'b0;
            last_read <= 1'b0;
        end else begin
            awready_q <= grant_wr;
            wready_q  <= grant_wr;
            arready_q <= grant_rd;
            start_q   <= grant_wr || grant_rd;
            if (grant_wr) begin
                last_read <= 1'b0;
            end else if (grant_rd) begin
                last_read <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_wr) begin
            addr_q  <= awaddr;
            prot_q  <= awprot;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end else if (grant_rd) begin
            addr_q  <= araddr;
            prot_q  <= arprot;
            // pstrb stays low on reads
            wstrb_q <= '0;
        end
    end

    assign awready       = awready_q;
    assign wready        = wready_q;
    assign arready       = arready_q;
    assign start         = start_q;
    assign load          = start_q;
    assign op            = last_read ? OP_READ : OP_WRITE;
    assign addr          = addr_q;
    assign prot          = prot_q;
    assign first_seg     = addr_q[`SEG_IDX_W-1:0];
    assign lane_wdata_in = wdata_q;
    assign lane_wstrb_in = wstrb_q;

endmodule

`default_nettype wire

// ==== axil_resp_gen.sv ====
// AXI4-Lite response generator

`timescale 1ns/1ns
`default_nettype none

module axil_resp_gen (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire axil_pkg::axil_op_t   op,
    input  wire logic                 xfer_done,
    input  wire logic                 seg_err,
    input  wire axil_pkg::axil_data_t lane_rdata_bus,
    input  wire logic                 bready,
    input  wire logic                 rready,
    output logic                      bvalid,
    output axil_pkg::axil_resp_t      bresp,
    output logic                      rvalid,
    output axil_pkg::axil_data_t      rdata,
    output axil_pkg::axil_resp_t      rresp,
    output logic                      b_free,
    output logic                      r_free
);
    import axil_pkg::*;

    logic err_q;
    logic resp_err;

    // sticky over all segments of one transfer
    assign resp_err = err_q || seg_err;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            bvalid <= bvalid && !bready;
            rvalid <= rvalid && !rready;
            if (xfer_done) begin
                err_q <= 1'b0;
                if (op == OP_WRITE) begin
                    bvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                end
            end else if (seg_err) begin
                err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_done) begin
            if (op == OP_WRITE) begin
                bresp <= resp_err ? RESP_SLVERR : RESP_OKAY;
            end else begin
                rresp <= resp_err ? RESP_SLVERR : RESP_OKAY;
                rdata <= lane_rdata_bus;
            end
        end
    end

    assign b_free = !bvalid || bready;
    assign r_free = !rvalid || rready;

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
axil_pkg.sv
apb_pkg.sv
axil_req_arbiter.sv
apb_seg_lane.sv
apb_seq.sv
axil_resp_gen.sv
axil_apb_bridge.sv
tb_apb_mem.sv
tb_axil_apb_bridge.sv

// ==== tb_apb_mem.sv ====
// APB completer model

`timescale 1ns/1ns
`default_nettype none

`include "adapter_params.svh"

module tb_apb_mem (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [`ADDR_W-1:0] paddr,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [7:0]        pwdata,
    input  wire logic              pstrb,
    output logic [7:0]             prdata,
    output logic                   pready,
    output logic                   pslverr
);
    logic [7:0] mem [0:255];
    logic [7:0] lfsr;
    logic [1:0] wait_cnt;
    logic       err_region;

    // taps 8 6 5 4, new bit enters at the bottom
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // one lfsr step per wait-state bit
    function automatic logic [1:0] wait_bits(input logic [7:0] s);
        logic [7:0] s1;
        logic [7:0] s2;
        s1 = lfsr_next(s);
        s2 = lfsr_next(s1);
        return {s1[0], s2[0]};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = i[7:0];
        end
    end

    assign err_region = (paddr[`ADDR_W-1:`ADDR_W-4] == 4'hF);
    assign pready     = psel && penable && (wait_cnt == 2'd0);
    assign pslverr    = pready && err_region;
    assign prdata     = mem[paddr[7:0]];

    always @(posedge clk) begin
        if (rst) begin
            wait_cnt <= 2'd0;
            lfsr     <= 8'd98;
        end else begin
            if (psel && !penable) begin
                wait_cnt <= wait_bits(lfsr);
                lfsr     <= lfsr_next(lfsr_next(lfsr));
            end else if (psel && penable && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            // errored writes leave memory alone
            if (pready && pwrite && pstrb && !err_region) begin
                mem[paddr[7:0]] <= pwdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_axil_apb_bridge.sv ====
// AXI4-Lite to APB bridge testbench

`timescale 1ns/1ns
`default_nettype none

`include "adapter_params.svh"

module tb_axil_apb_bridge;
    import axil_pkg::*;
    import apb_pkg::*;

    typedef struct packed {
        axil_op_t   op;
        axil_addr_t addr;
        axil_data_t wdata;
        axil_strb_t strb;
        axil_data_t exp_rdata;
        axil_resp_t exp_resp;
        logic [3:0] hold;
        logic       pair;
    } row_t;

    logic       clk = 1'b0;
    logic       rst;
    axil_addr_t awaddr;
    logic [2:0] awprot;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic [2:0] arprot;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;
    axil_addr_t paddr;
    logic [2:0] pprot;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_data_t  pwdata;
    logic       pstrb;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;

    row_t rows[$];
    int   idx;

    axil_apb_bridge dut_i (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .paddr(paddr), .pprot(pprot), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    tb_apb_mem mem_i (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #5 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first failed check");
        end
    endtask

    function automatic void add_row(input axil_op_t op, input axil_addr_t addr,
                                    input axil_data_t data, input axil_strb_t strb,
                                    input axil_data_t exp, input axil_resp_t resp,
                                    input logic [3:0] hold, input logic pair);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.wdata     = data;
        r.strb      = strb;
        r.exp_rdata = exp;
        r.exp_resp  = resp;
        r.hold      = hold;
        r.pair      = pair;
        rows.push_back(r);
    endfunction

    // memory starts with each location holding its own low address byte
    function automatic void build_table();
        add_row(OP_WRITE, 16'h0010, 32'hA1B2C3D4, 4'hF, 32'h0, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0010, 32'h0, 4'h0, 32'hA1B2C3D4, RESP_OKAY, 4'd2, 1'b0);
        add_row(OP_WRITE, 16'h0020, 32'h55667788, 4'h5, 32'h0, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0020, 32'h0, 4'h0, 32'h23662188, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0032, 32'h0, 4'h0, 32'h33320000, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0013, 32'h0, 4'h0, 32'hA1000000, RESP_OKAY, 4'd1, 1'b0);
        // start at lane 1, so byte 0 is never written
        add_row(OP_WRITE, 16'h0041, 32'h11223344, 4'hF, 32'h0, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0040, 32'h0, 4'h0, 32'h11223340, RESP_OKAY, 4'd0, 1'b0);
        // error region aliases low byte 0x10
        add_row(OP_WRITE, 16'hF010, 32'hDEADBEEF, 4'hF, 32'h0, RESP_SLVERR, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0010, 32'h0, 4'h0, 32'hA1B2C3D4, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'hF016, 32'h0, 4'h0, 32'h0, RESP_SLVERR, 4'd3, 1'b0);
        add_row(OP_READ, 16'h0044, 32'h0, 4'h0, 32'h47464544, RESP_OKAY, 4'd0, 1'b0);
        // write and read presented together
        add_row(OP_WRITE, 16'h0050, 32'hCAFEF00D, 4'hF, 32'h0, RESP_OKAY, 4'd6, 1'b1);
        add_row(OP_READ, 16'h0060, 32'h0, 4'h0, 32'h63626160, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_WRITE, 16'h0070, 32'h0BADC0DE, 4'h3, 32'h0, RESP_OKAY, 4'd0, 1'b1);
        add_row(OP_READ, 16'h0020, 32'h0, 4'h0, 32'h23662188, RESP_OKAY, 4'd5, 1'b0);
        add_row(OP_READ, 16'h0050, 32'h0, 4'h0, 32'hCAFEF00D, RESP_OKAY, 4'd0, 1'b0);
        add_row(OP_READ, 16'h0070, 32'h0, 4'h0, 32'h7372C0DE, RESP_OKAY, 4'd0, 1'b0);
    endfunction

    task automatic write_access(input int n);
        row_t r;
        r = rows[n];
        @(negedge clk);
        awaddr  = r.addr;
        // protection varies with the row
        awprot  = n[2:0];
        wdata   = r.wdata;
        wstrb   = r.strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_value(wready, 1'b1, $sformatf("row %0d wready with awready", n));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (r.hold) begin
            @(negedge clk);
            check_value(bvalid, 1'b1, $sformatf("row %0d bvalid under back-pressure", n));
        end
        check_value(bresp, r.exp_resp, $sformatf("row %0d bresp", n));
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_value(bvalid, 1'b0, $sformatf("row %0d bvalid after handshake", n));
    endtask

    task automatic read_access(input int n);
        row_t r;
        r = rows[n];
        @(negedge clk);
        araddr  = r.addr;
        arprot  = n[2:0];
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (r.hold) begin
            @(negedge clk);
            check_value(rvalid, 1'b1, $sformatf("row %0d rvalid under back-pressure", n));
        end
        check_value(rresp, r.exp_resp, $sformatf("row %0d rresp", n));
        if (r.exp_resp == RESP_OKAY) begin
            check_value(rdata, r.exp_rdata, $sformatf("row %0d rdata", n));
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_value(rvalid, 1'b0, $sformatf("row %0d rvalid after handshake", n));
    endtask

    task automatic run_row(input int n);
        if (rows[n].op == OP_WRITE) begin
            write_access(n);
        end else begin
            read_access(n);
        end
    endtask

    // pprot follows the prot of the request being transferred
    always @(negedge clk) begin
        if (!rst && psel) begin
            check_value(pprot, pwrite ? awprot : arprot, "pprot during apb transfer");
        end
    end

    initial begin
        build_table();
        rst     = 1'b1;
        awaddr  = '0;
        awprot  = 3'b000;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arprot  = 3'b000;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value({awready, wready, arready, bvalid, rvalid, psel, penable}, '0,
                    "handshake outputs after reset");
        idx = 0;
        while (idx < rows.size()) begin
            if (rows[idx].pair && idx + 1 < rows.size()) begin
                fork
                    run_row(idx);
                    run_row(idx + 1);
                join
                idx = idx + 2;
            end else begin
                run_row(idx);
                idx = idx + 1;
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

    // generous budget per table row
    initial begin
        #1;
        repeat (rows.size() * 200) @(posedge clk);
        $display("error: the table did not finish in time, a handshake never completed");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
